/* Makefile */
# SD host command path, Verilator flow

VERILATOR ?= verilator
TOP       ?= tb_sd_host
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cmd_patterns.txt */
# name clk_div index argument resp_expect card_mode expected_status expected_resp (hex)
# card_mode 0 answer, 1 silent, 2 bad crc, 3 index + 1; rand_* draws its argument at run time
no_resp_div0  00 00 00000000 0 1 02 00000000
no_resp_div3  03 07 12345678 0 1 02 00000000
resp_div0     00 11 00000000 1 0 02 a5a5a5a5
resp_div1     01 08 000001aa 1 0 02 a5a5a40f
resp_div5     05 37 deadbeef 1 0 02 7b081b4a
resp_index3f  00 3f ffffffff 1 0 02 5a5a5a5a
silent_card   01 0d 00000000 1 1 06 00000000
bad_crc       00 11 cafef00d 1 2 0a 6f5b55a8
bad_index     02 12 0f0f0f0f 1 3 12 aaaaaaaa
busy_write    01 11 13572468 1 0 02 b6f281cd
rand_arg      03 2a 00000000 1 0 02 00000000

/* sd_card_model.sv */
/*
 * Behavioral SD card for the command path testbench
 * takes 48-bit commands from the CMD line and answers with a short response,
 * or stays silent, breaks the CRC or echoes index + 1 when told to
 */
module sd_card_model
   import sd_host_pkg::*;
(
   input  logic       rst_n,
   input  logic       sd_clk,
   input  logic       cmd_out,     // host side of the line
   input  logic       cmd_oe,
   input  logic [1:0] mode,        // 0 answer, 1 silent, 2 bad crc, 3 index + 1
   output logic       cmd_line     // resolved CMD line, back to the host
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [CMD_FRAME_BITS-1:0] rx_frame = '0;
   logic [CMD_FRAME_BITS-1:0] tx_frame = '1;
   int                        rx_cnt = 0;
   int                        tx_cnt = 0;
   int                        gap = 0;
   logic                      receiving = 1'b0;
   logic                      sending = 1'b0;
   logic                      card_oe = 1'b0;
   logic                      card_out = 1'b1;

   // open line, pulled up while nobody pulls it low
   assign cmd_line = (cmd_oe ? cmd_out : 1'b1) & (card_oe ? card_out : 1'b1);

   // CRC7 over the first 40 bits, x^7 + x^3 + 1, msb first
   function automatic sd_crc_t crc7_of(input logic [39:0] bits);
      sd_crc_t c;
      logic    fb;
      c = '0;
      for (int i = 39; i >= 0; i--) begin
         fb = bits[i] ^ c[6];
         c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
      end
      return c;
   endfunction

   function automatic logic [47:0] make_response(input logic [47:0] cmd, input logic [1:0] m);
      sd_index_t idx;
      sd_arg_t   arg;
      sd_crc_t   crc;
      idx = cmd[45:40];
      if (m == 2'd3) begin
         idx = idx + 1'b1;       // wrong echo on purpose
      end
      arg = cmd[39:8] ^ 32'hA5A5A5A5;
      crc = crc7_of({2'b00, idx, arg});
      if (m == 2'd2) begin
         crc = crc ^ 7'h01;
      end
      return {2'b00, idx, arg, crc, 1'b1};
   endfunction

   // sample on the rising card clock edge, drive on the falling one
   always @(posedge sd_clk or negedge sd_clk) begin
      if (!rst_n) begin
         receiving = 1'b0;
         sending   = 1'b0;
         card_oe   = 1'b0;
         card_out  = 1'b1;
      end else if (sd_clk) begin
         if (cmd_oe && sending) begin
            sending  = 1'b0;     // host took the line back
            card_oe  = 1'b0;
            card_out = 1'b1;
         end
         if (receiving) begin
            rx_frame = {rx_frame[CMD_FRAME_BITS-2:0], cmd_line};
            rx_cnt++;
            if (rx_cnt == CMD_FRAME_BITS) begin
               receiving = 1'b0;
               if (mode != 2'd1) begin
                  tx_frame = make_response(rx_frame, mode);
                  tx_cnt   = 0;
                  gap      = 1;  // one card clock after the end bit
                  sending  = 1'b1;
               end
            end
         end else if (!sending && !cmd_line) begin
            receiving = 1'b1;    // start bit
            rx_frame  = '0;
            rx_cnt    = 1;
         end
      end else if (sending) begin
         if (gap > 0) begin
            gap--;
         end else if (tx_cnt < CMD_FRAME_BITS) begin
            card_oe  = 1'b1;
            card_out = tx_frame[CMD_FRAME_BITS-1-tx_cnt];
            tx_cnt++;
         end else begin
            card_oe  = 1'b0;
            card_out = 1'b1;
            sending  = 1'b0;
         end
      end
   end

endmodule

/* sd_cmd_engine.sv */
/*
 * SD command engine
 * divides clk down to the card clock, shifts out the 48-bit command frame
 * with CRC7 and receives an optional short response with CRC, index and
 * timeout checks
 */
module sd_cmd_engine
   import sd_host_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  cmd_req_t    cmd_req,
   input  logic        cmd_start,
   input  clk_div_t    clk_div,
   output logic        cmd_busy,
   output logic        cmd_done,
   output cmd_result_t cmd_result,
   // card side
   output logic        sd_clk,
   output logic        cmd_out,
   output logic        cmd_oe,
   input  logic        cmd_in
);

   cmd_state_t                state;
   cmd_req_t                  req_q;        // request held for the whole command
   clk_div_t                  div_cnt;
   logic                      run;
   logic                      div_end;
   logic                      clk_rise;
   logic                      clk_fall;
   logic                      start_ok;
   logic [5:0]                bit_cnt;
   logic [5:0]                to_cnt;
   logic [CMD_FRAME_BITS-1:0] tx_sr;
   logic [CMD_FRAME_BITS-1:0] rx_sr;
   logic                      timeout_q;
   logic                      tx_crc_shift;
   logic                      resp_start;
   logic                      rx_sample;
   logic                      rx_crc_shift;
   logic                      resp_checked;
   sd_crc_t                   tx_crc;
   sd_crc_t                   rx_crc;

   ////////////////////////////////////////////////////////////////////////////
   // card clock, runs only while a frame is in flight
   ////////////////////////////////////////////////////////////////////////////
   assign run      = (state == CMD_SEND) || (state == CMD_WAIT_RESP) || (state == CMD_RECV);
   assign div_end  = (div_cnt == clk_div);
   assign clk_rise = run && div_end && !sd_clk;
   assign clk_fall = run && div_end && sd_clk;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         div_cnt <= '0;
         sd_clk  <= 1'b0;
      end else if (!run) begin
         div_cnt <= '0;
         sd_clk  <= 1'b0;     // park low when idle
      end else if (div_end) begin
         div_cnt <= '0;
         sd_clk  <= !sd_clk;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign start_ok     = cmd_start && (state == CMD_IDLE) && !cmd_busy;
   assign cmd_out      = tx_sr[CMD_FRAME_BITS-1];
   assign tx_crc_shift = (state == CMD_SEND) && clk_rise && (bit_cnt < 6'(CRC_SPAN_BITS));
   assign resp_start   = (state == CMD_WAIT_RESP) && clk_rise && !cmd_in;
   assign rx_sample    = resp_start || ((state == CMD_RECV) && clk_rise);
   assign rx_crc_shift = resp_start ||
                         ((state == CMD_RECV) && clk_rise && (bit_cnt < 6'(CRC_SPAN_BITS)));
   assign resp_checked = req_q.resp_expect && !timeout_q;

   // CRC over the frame as it goes out, and over the response as it comes in
   sd_crc7 i_tx_crc (
      .clk    (clk),
      .rst_n  (rst_n),
      .clear  (start_ok),
      .shift  (tx_crc_shift),
      .bit_in (cmd_out),
      .crc    (tx_crc)
   );

   sd_crc7 i_rx_crc (
      .clk    (clk),
      .rst_n  (rst_n),
      .clear  (start_ok),
      .shift  (rx_crc_shift),
      .bit_in (cmd_in),
      .crc    (rx_crc)
   );

   ////////////////////////////////////////////////////////////////////////////
   // command FSM
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= CMD_IDLE;
         bit_cnt   <= '0;
         to_cnt    <= '0;
         tx_sr     <= '1;         // line idles high
         cmd_oe    <= 1'b0;
         cmd_busy  <= 1'b0;
         cmd_done  <= 1'b0;
         timeout_q <= 1'b0;
      end else begin
         cmd_done <= 1'b0;
         if (cmd_done) begin
            cmd_busy <= 1'b0;     // busy covers the done cycle
         end
         case (state)
            CMD_IDLE: begin
               if (start_ok) begin
                  state     <= CMD_SEND;
                  cmd_busy  <= 1'b1;
                  cmd_oe    <= 1'b1;
                  bit_cnt   <= '0;
                  to_cnt    <= '0;
                  timeout_q <= 1'b0;
                  // start, direction, index, arg, crc slot, end
                  tx_sr     <= {1'b0, 1'b1, cmd_req.index, cmd_req.arg, 7'h7f, 1'b1};
               end
            end
            CMD_SEND: begin
               if (clk_fall) begin
                  if (bit_cnt == 6'(CMD_FRAME_BITS - 1)) begin
                     cmd_oe  <= 1'b0;
                     bit_cnt <= '0;
                     state   <= req_q.resp_expect ? CMD_WAIT_RESP : CMD_DONE;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
                  if (bit_cnt == 6'(CRC_SPAN_BITS - 1)) begin
                     tx_sr <= {tx_crc, {(CMD_FRAME_BITS - 7){1'b1}}};  // crc then end bit
                  end else begin
                     tx_sr <= {tx_sr[CMD_FRAME_BITS-2:0], 1'b1};
                  end
               end
            end
            CMD_WAIT_RESP: begin
               if (resp_start) begin
                  state   <= CMD_RECV;
                  bit_cnt <= 6'd1;    // start bit already taken
               end else if (clk_rise) begin
                  if (to_cnt == 6'(RESP_TIMEOUT - 1)) begin
                     timeout_q <= 1'b1;
                     state     <= CMD_DONE;
                  end else begin
                     to_cnt <= to_cnt + 1'b1;
                  end
               end
            end
            CMD_RECV: begin
               if (clk_rise) begin
                  if (bit_cnt == 6'(CMD_FRAME_BITS - 1)) begin
                     state <= CMD_DONE;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            CMD_DONE: begin
               cmd_done <= 1'b1;
               state    <= CMD_IDLE;
            end
            default: state <= CMD_IDLE;
         endcase
      end
   end

   // response shift register and result, payload only
   always_ff @(posedge clk) begin
      if (start_ok) begin
         req_q <= cmd_req;
         rx_sr <= '0;
      end else if (rx_sample) begin
         rx_sr <= {rx_sr[CMD_FRAME_BITS-2:0], cmd_in};
      end
      if (state == CMD_DONE) begin
         cmd_result.index     <= rx_sr[45:40];
         cmd_result.arg       <= rx_sr[39:8];
         cmd_result.timeout   <= timeout_q;
         cmd_result.crc_err   <= resp_checked && (rx_sr[7:1] != rx_crc);
         cmd_result.index_err <= resp_checked && (rx_sr[45:40] != req_q.index);
      end
   end

endmodule

/* sd_crc7.sv */
/*
 * Serial CRC7, polynomial x^7 + x^3 + 1
 * one bit per shift strobe, cleared before each frame
 */
module sd_crc7
   import sd_host_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    clear,
   input  logic    shift,
   input  logic    bit_in,
   output sd_crc_t crc
);

   logic fb;

   assign fb = bit_in ^ crc[6];   // feedback from the top bit

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         crc <= '0;
      end else if (clear) begin
         crc <= '0;
      end else if (shift) begin
         crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
      end
   end

endmodule

/* sd_host.sv */
/*
 * SD host controller, command path top level
 * register block on the host bus plus the CMD line engine
 */
module sd_host
   import sd_host_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   // host bus
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  wb_adr_t     wb_adr,
   input  logic [31:0] wb_dat_w,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack,
   output logic        irq,
   // card
   output logic        sd_clk,
   output logic        cmd_out,
   output logic        cmd_oe,
   input  logic        cmd_in
);

   cmd_req_t    cmd_req;
   cmd_result_t cmd_result;
   clk_div_t    clk_div;
   logic        cmd_start;
   logic        cmd_busy;
   logic        cmd_done;

   sd_host_regs i_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .cmd_req    (cmd_req),
      .cmd_start  (cmd_start),
      .clk_div    (clk_div),
      .cmd_busy   (cmd_busy),
      .cmd_done   (cmd_done),
      .cmd_result (cmd_result),
      .irq        (irq)
   );

   sd_cmd_engine i_cmd_engine (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_req    (cmd_req),
      .cmd_start  (cmd_start),
      .clk_div    (clk_div),
      .cmd_busy   (cmd_busy),
      .cmd_done   (cmd_done),
      .cmd_result (cmd_result),
      .sd_clk     (sd_clk),
      .cmd_out    (cmd_out),
      .cmd_oe     (cmd_oe),
      .cmd_in     (cmd_in)
   );

endmodule

/* sd_host_pkg.sv */
/*
 * SD host command path shared definitions
 * widths, register map, frame timing, request/result structs and FSM states
 */
package sd_host_pkg;

   // widths that carry a meaning
   typedef logic [31:0] sd_arg_t;   // command argument or response payload
   typedef logic [5:0]  sd_index_t; // command index
   typedef logic [6:0]  sd_crc_t;   // CRC7 remainder
   typedef logic [7:0]  clk_div_t;  // card clock period = 2*(value+1) clk
   typedef logic [2:0]  wb_adr_t;   // register word address

   ////////////////////////////////////////////////////////////////////////////
   // register map
   ////////////////////////////////////////////////////////////////////////////
   localparam wb_adr_t REG_ARG    = 3'd0;
   localparam wb_adr_t REG_CMD    = 3'd1; // [5:0] index, [8] resp_expect, [21:16] resp index
   localparam wb_adr_t REG_RESP   = 3'd2;
   localparam wb_adr_t REG_STATUS = 3'd3; // busy, complete, timeout, crc_err, index_err
   localparam wb_adr_t REG_CLKDIV = 3'd4;

   localparam int CMD_RESP_BIT = 8;       // resp_expect position in REG_CMD

   // frame and timing
   localparam int CMD_FRAME_BITS = 48;
   localparam int CRC_SPAN_BITS  = CMD_FRAME_BITS - 8;  // bits covered by CRC7
   localparam int RESP_TIMEOUT   = 64;    // card clocks to wait for start bit

   ////////////////////////////////////////////////////////////////////////////
   // register block <-> engine
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      sd_index_t index;
      sd_arg_t   arg;
      logic      resp_expect;
   } cmd_req_t;

   typedef struct packed {
      sd_index_t index;      // echoed index from the card
      sd_arg_t   arg;        // response payload
      logic      timeout;
      logic      crc_err;
      logic      index_err;
   } cmd_result_t;

   typedef enum logic [2:0] {
      CMD_IDLE,
      CMD_SEND,
      CMD_WAIT_RESP,
      CMD_RECV,
      CMD_DONE
   } cmd_state_t;

endpackage

/* sd_host_regs.sv */
/*
 * SD host register block
 * Wishbone classic slave holding argument, command, response, status and
 * card clock divider, issues command starts and drives the interrupt
 */
module sd_host_regs
   import sd_host_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   // host bus
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  wb_adr_t     wb_adr,
   input  logic [31:0] wb_dat_w,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack,
   // command engine
   output cmd_req_t    cmd_req,
   output logic        cmd_start,
   output clk_div_t    clk_div,
   input  logic        cmd_busy,
   input  logic        cmd_done,
   input  cmd_result_t cmd_result,
   output logic        irq
);

   logic        served;       // acked already, wait for stb to drop
   logic        access;
   logic        wr_en;
   logic        cmd_accept;
   logic [3:0]  sticky;       // index_err, crc_err, timeout, complete
   logic [3:0]  sticky_next;
   sd_arg_t     resp_arg;
   sd_index_t   resp_index;
   logic [31:0] rd_data;

   assign access     = wb_cyc && wb_stb && !served;
   assign wr_en      = access && wb_we;
   assign cmd_accept = wr_en && (wb_adr == REG_CMD) && !cmd_busy && !cmd_start;
   assign irq        = |sticky;

   ////////////////////////////////////////////////////////////////////////////
   // bus handshake
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_ack <= 1'b0;
         served <= 1'b0;
      end else begin
         wb_ack <= access;            // single cycle pulse
         served <= wb_cyc && wb_stb;
      end
   end

   // sticky status, done wins over a clear in the same cycle
   always_comb begin
      sticky_next = sticky;
      if (wr_en && (wb_adr == REG_STATUS)) begin
         sticky_next = sticky & ~wb_dat_w[4:1];
      end
      if (cmd_done) begin
         sticky_next = sticky_next | {cmd_result.index_err, cmd_result.crc_err,
                                      cmd_result.timeout, 1'b1};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // control registers
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cmd_start <= 1'b0;
         clk_div   <= '0;
         sticky    <= '0;
      end else begin
         cmd_start <= cmd_accept;     // writes while busy are dropped
         if (wr_en && (wb_adr == REG_CLKDIV)) begin
            clk_div <= wb_dat_w[7:0];
         end
         sticky <= sticky_next;
      end
   end

   // payload registers
   always_ff @(posedge clk) begin
      if (wr_en && (wb_adr == REG_ARG)) begin
         cmd_req.arg <= wb_dat_w;
      end
      if (cmd_accept) begin
         cmd_req.index       <= wb_dat_w[5:0];
         cmd_req.resp_expect <= wb_dat_w[CMD_RESP_BIT];
      end
      if (cmd_done) begin
         resp_arg   <= cmd_result.arg;
         resp_index <= cmd_result.index;
      end
      if (access) begin
         wb_dat_r <= rd_data;         // valid in the ack cycle
      end
   end

   // read mux
   always_comb begin
      case (wb_adr)
         REG_ARG:    rd_data = cmd_req.arg;
         REG_CMD:    rd_data = {10'd0, resp_index, 7'd0, cmd_req.resp_expect,
                                2'd0, cmd_req.index};
         REG_RESP:   rd_data = resp_arg;
         REG_STATUS: rd_data = {27'd0, sticky, cmd_busy || cmd_start};
         REG_CLKDIV: rd_data = {24'd0, clk_div};
         default:    rd_data = '0;
      endcase
   end

endmodule

/* tb.f */
sd_host_pkg.sv
sd_crc7.sv
sd_host_regs.sv
sd_cmd_engine.sv
sd_host.sv
sd_card_model.sv
tb_sd_host.sv

/* tb_sd_host.sv */
/*
 * Testbench for the SD host command path
 * runs the commands listed in cmd_patterns.txt over Wishbone against a
 * behavioral card and checks STATUS, RESP and the interrupt
 */
module tb_sd_host
   import sd_host_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   logic        clk;
   logic        rst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   wb_adr_t     wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   logic        irq;
   logic        sd_clk;
   logic        cmd_out;
   logic        cmd_oe;
   logic        cmd_line;
   logic [1:0]  card_mode;

   int unsigned cycle_cnt = 0;
   integer      seed = 69337;
   string       cur_test;
   int          test_errors = 0;
   int          total_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   sd_host i_sd_host (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .irq      (irq),
      .sd_clk   (sd_clk),
      .cmd_out  (cmd_out),
      .cmd_oe   (cmd_oe),
      .cmd_in   (cmd_line)
   );

   sd_card_model i_card (
      .rst_n    (rst_n),
      .sd_clk   (sd_clk),
      .cmd_out  (cmd_out),
      .cmd_oe   (cmd_oe),
      .mode     (card_mode),
      .cmd_line (cmd_line)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;      // 8 ns period
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
         test_errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Wishbone master, driven on the falling edge
   ////////////////////////////////////////////////////////////////////////////
   task automatic bus_access(input wb_adr_t adr, input logic we, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      logic got;
      got   = 1'b0;
      rdata = '0;
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      for (int n = 0; n < 16 && !got; n++) begin
         @(negedge clk);
         if (wb_ack) begin
            got   = 1'b1;
            rdata = wb_dat_r;     // read data valid with ack
         end
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      assert (got) else begin
         $display("ERROR %s: no Wishbone ack from address %0d", cur_test, adr);
         test_errors++;
      end
   endtask

   task automatic bus_write(input wb_adr_t adr, input logic [31:0] data);
      logic [31:0] unused;
      bus_access(adr, 1'b1, data, unused);
   endtask

   task automatic bus_read(input wb_adr_t adr, output logic [31:0] data);
      bus_access(adr, 1'b0, 32'd0, data);
   endtask

   // poll STATUS until busy drops
   task automatic wait_idle();
      logic [31:0] st;
      int unsigned t0;
      t0 = cycle_cnt;
      st = 32'd1;
      while (st[0] && (cycle_cnt - t0 < 20000)) begin
         bus_read(REG_STATUS, st);
      end
      assert (!st[0]) else begin
         $display("ERROR %s: engine still busy after 20000 cycles", cur_test);
         test_errors++;
      end
   endtask

   task automatic finish_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors == 0) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: FAILED with %0d errors", cur_test, test_errors);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_registers();
      logic [31:0] rd;
      cur_test    = "reg_access";
      test_errors = 0;
      check_value("irq after reset", 32'd0, 32'(irq));
      check_value("wb_ack after reset", 32'd0, 32'(wb_ack));
      check_value("sd_clk after reset", 32'd0, 32'(sd_clk));
      check_value("cmd_oe after reset", 32'd0, 32'(cmd_oe));
      check_value("cmd_out after reset", 32'd1, 32'(cmd_out));
      bus_read(REG_STATUS, rd);
      check_value("STATUS after reset", 32'd0, rd);
      bus_read(REG_CLKDIV, rd);
      check_value("CLKDIV after reset", 32'd0, rd);
      bus_write(REG_ARG, 32'h5a5a_1234);
      bus_read(REG_ARG, rd);
      check_value("ARG", 32'h5a5a_1234, rd);
      bus_write(REG_CLKDIV, 32'h0000_003c);
      bus_read(REG_CLKDIV, rd);
      check_value("CLKDIV", 32'h0000_003c, rd);
      for (int a = 5; a < 8; a++) begin
         bus_read(wb_adr_t'(a), rd);
         check_value("unused address", 32'd0, rd);
      end
      finish_test();
   endtask

   task automatic run_command(input string name, input logic [31:0] div, input logic [31:0] idx,
                              input logic [31:0] arg, input logic [31:0] rexp,
                              input logic [31:0] mode, input logic [31:0] est,
                              input logic [31:0] eresp);
      logic [31:0] rd;
      logic [31:0] cmd_word;
      sd_arg_t     a;
      sd_arg_t     exp_resp;
      sd_index_t   exp_index;
      cur_test    = name;
      test_errors = 0;
      a           = arg;
      exp_resp    = eresp;
      if (name.len() >= 4 && name.substr(0, 3) == "rand") begin
         a        = $random(seed);
         exp_resp = a ^ 32'hA5A5A5A5;   // card answers with the argument XOR A5A5A5A5
      end
      // card echoes the index, or index + 1 in the wrong-echo mode
      exp_index = (mode[1:0] == 2'd3) ? idx[5:0] + 1'b1 : idx[5:0];
      cmd_word  = {23'd0, rexp[0], 2'b00, idx[5:0]};
      @(negedge clk);
      card_mode = mode[1:0];
      bus_write(REG_CLKDIV, div);
      bus_write(REG_ARG, a);
      bus_write(REG_CMD, cmd_word);
      if (name == "busy_write") begin
         bus_read(REG_STATUS, rd);
         check_value("busy", 32'd1, 32'(rd[0]));
         bus_write(REG_CMD, {23'd0, rexp[0], 2'b00, ~idx[5:0]});   // must be dropped
      end
      wait_idle();
      bus_read(REG_STATUS, rd);
      check_value("STATUS", est, rd);
      bus_read(REG_RESP, rd);
      check_value("RESP", exp_resp, rd);
      bus_read(REG_CMD, rd);
      check_value("CMD", cmd_word, rd & 32'h0000_01ff);
      if (rexp[0] && mode[1:0] != 2'd1) begin
         check_value("response index", 32'(exp_index), 32'(rd[21:16]));
      end
      check_value("irq", 32'(|est[4:1]), 32'(irq));
      bus_write(REG_STATUS, 32'h0000_001e);    // write 1 to clear
      bus_read(REG_STATUS, rd);
      check_value("STATUS after clear", 32'd0, rd);
      check_value("irq after clear", 32'd0, 32'(irq));
      finish_test();
   endtask

   initial begin
      int          fd;
      int          n;
      string       line;
      string       name;
      logic [31:0] div;
      logic [31:0] idx;
      logic [31:0] arg;
      logic [31:0] rexp;
      logic [31:0] mode;
      logic [31:0] est;
      logic [31:0] eresp;
      rst_n     = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      card_mode = 2'd1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      check_registers();

      fd = $fopen("cmd_patterns.txt", "r");
      if (fd == 0) begin
         $display("ERROR could not open cmd_patterns.txt");
         total_errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n <= 0 || line.len() == 0 || line[0] == "#") begin
               continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h", name, div, idx, arg, rexp, mode,
                        est, eresp);
            if (n == 8) begin
               run_command(name, div, idx, arg, rexp, mode, est, eresp);
            end
         end
         $fclose(fd);
      end

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
      if (total_errors == 0 && tests_failed == 0 && tests_run > 1) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
